/* include/apb_mon_params.svh */
/*
 * APB3 protocol monitor parameters
 * Bus widths, configuration register offsets and the CTRL reset value
 */
`ifndef APB_MON_PARAMS_SVH
`define APB_MON_PARAMS_SVH

// Monitored bus widths
`define APB_MON_ADDR_W      32
`define APB_MON_DATA_W      32

// Configuration port address width
`define APB_MON_CFG_ADDR_W  8

// Transfer counters and wait tracking
`define APB_MON_CNT_W       16
`define APB_MON_WAIT_W      8

// Register map of the configuration port
`define APB_MON_REG_CTRL    'h00
`define APB_MON_REG_STATUS  'h04
`define APB_MON_REG_WR_CNT  'h08
`define APB_MON_REG_RD_CNT  'h0C
`define APB_MON_REG_ERR_CNT 'h10

// Checking on, wait limit off, limit of zero
`define APB_MON_CTRL_RESET  32'h0000_0001

`endif

/* source/apb_mon_pkg.sv */
/*
 * APB3 protocol monitor types
 * Vector typedefs, bus phase encoding and violation bit positions
 */
`include "apb_mon_params.svh"

package apb_mon_pkg;

    typedef logic [`APB_MON_ADDR_W-1:0]     addr_t;
    typedef logic [`APB_MON_DATA_W-1:0]     data_t;
    typedef logic [`APB_MON_CFG_ADDR_W-1:0] cfg_addr_t;
    typedef logic [`APB_MON_CNT_W-1:0]      cnt_t;
    typedef logic [`APB_MON_WAIT_W-1:0]     wait_t;
    typedef logic [7:0]                     viol_t;

    // PH_BAD is PENABLE high with PSEL low
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SETUP,
        PH_ACCESS,
        PH_BAD
    } apb_phase_e;

    // Bit positions in STATUS and in the violation vector
    localparam int V_SETUP_TO_ACCESS = 0;
    localparam int V_PENABLE_NO_PSEL = 1;
    localparam int V_PENABLE_FIRST   = 2;
    localparam int V_SETUP_UNSTABLE  = 3;
    localparam int V_WAIT_UNSTABLE   = 4;
    localparam int V_WAIT_LIMIT      = 5;
    localparam int V_PSLVERR_IDLE    = 6;
    localparam int V_IDLE_UNSTABLE   = 7;

endpackage

/* source/apb_phase_tracker.sv */
/*
 * APB3 phase tracker
 * Decodes the bus phase, keeps last cycle's bus values and counts
 * consecutive wait cycles of the current ACCESS phase
 */
`timescale 1ns/10ps
`include "apb_mon_params.svh"

module apb_phase_tracker
    import apb_mon_pkg::*;
(
    input  logic       pclk,
    input  logic       presetn,
    input  logic       psel,
    input  logic       penable,
    input  addr_t      paddr,
    input  logic       pwrite,
    input  data_t      pwdata,
    input  logic       pready,
    output apb_phase_e phase,
    output apb_phase_e prev_phase,
    output logic       prev_psel,
    output addr_t      prev_paddr,
    output logic       prev_pwrite,
    output data_t      prev_pwdata,
    output logic       first_cycle,
    output wait_t      wait_cnt
);

    // Count saturates here instead of wrapping back to zero
    localparam wait_t WAIT_MAX = {`APB_MON_WAIT_W{1'b1}};

    // Phase straight from the select and enable levels
    always_comb begin
        case ({psel, penable})
            2'b00:   phase = PH_IDLE;
            2'b10:   phase = PH_SETUP;
            2'b11:   phase = PH_ACCESS;
            default: phase = PH_BAD;
        endcase
    end

    // Control history, cleared by reset
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            prev_phase  <= PH_IDLE;
            prev_psel   <= 1'b0;
            first_cycle <= 1'b1;
            wait_cnt    <= '0;
        end else begin
            prev_phase  <= phase;
            prev_psel   <= psel;
            first_cycle <= 1'b0;
            // Only an ACCESS cycle with PREADY low extends the run
            if ((phase == PH_ACCESS) && !pready) begin
                if (wait_cnt != WAIT_MAX) begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end else begin
                wait_cnt <= '0;
            end
        end
    end

    // Payload history, only compared once first_cycle has dropped
    always_ff @(posedge pclk) begin
        prev_paddr  <= paddr;
        prev_pwrite <= pwrite;
        prev_pwdata <= pwdata;
    end

    // One-shot flag stays down until the next reset
    a_first_cycle_once: assert property (
        @(posedge pclk) disable iff (!presetn)
        !first_cycle |=> !first_cycle
    ) else $error("first_cycle rose again without a reset");

endmodule

/* source/apb_rule_checker.sv */
/*
 * APB3 rule checker
 * Compares the live bus against last cycle's values and raises one flag
 * per broken rule, and decodes completed transfers by direction and error
 */
`timescale 1ns/10ps
`include "apb_mon_params.svh"

module apb_rule_checker
    import apb_mon_pkg::*;
(
    input  apb_phase_e phase,
    input  apb_phase_e prev_phase,
    input  logic       prev_psel,
    input  addr_t      prev_paddr,
    input  logic       prev_pwrite,
    input  data_t      prev_pwdata,
    input  logic       first_cycle,
    input  wait_t      wait_cnt,
    input  addr_t      paddr,
    input  logic       pwrite,
    input  data_t      pwdata,
    input  logic       penable,
    input  logic       pready,
    input  logic       pslverr,
    input  logic       wait_limit_on,
    input  wait_t      max_wait,
    output viol_t      viol,
    output logic       wr_done,
    output logic       rd_done,
    output logic       err_done
);

    logic in_access;
    logic xfer_end;
    logic in_wait;
    logic ctl_chg;
    logic wdata_chg;

    assign in_access = (phase == PH_ACCESS);

    // Last ACCESS cycle, the only one where PSLVERR is sampled
    assign xfer_end = in_access && penable && pready;

    // Previous cycle was an ACCESS wait state
    assign in_wait = (wait_cnt != '0);

    // Address or direction moved since the last edge
    assign ctl_chg = (paddr != prev_paddr) || (pwrite != prev_pwrite);

    // Write data only matters for a write
    assign wdata_chg = prev_pwrite && (pwdata != prev_pwdata);

    always_comb begin
        viol = '0;

        // SETUP lasts one cycle and must be followed by ACCESS
        viol[V_SETUP_TO_ACCESS] = (prev_phase == PH_SETUP) && !in_access;

        viol[V_PENABLE_NO_PSEL] = (phase == PH_BAD);

        // No SETUP cycle before this ACCESS
        viol[V_PENABLE_FIRST] = in_access && !prev_psel;

        viol[V_SETUP_UNSTABLE] = (prev_phase == PH_SETUP) && in_access
                                 && (ctl_chg || wdata_chg);

        // Leaving ACCESS early also counts as a select change
        viol[V_WAIT_UNSTABLE] = in_wait && (!in_access || ctl_chg || wdata_chg);

        // max_wait wait cycles already behind us and PREADY still low
        viol[V_WAIT_LIMIT] = wait_limit_on && in_access && !pready
                             && (wait_cnt >= max_wait);

        viol[V_PSLVERR_IDLE] = pslverr && !xfer_end;

        // Address and direction parked while idle
        viol[V_IDLE_UNSTABLE] = !first_cycle && (phase == PH_IDLE) && ctl_chg;
    end

    // Completion pulses for the counters
    assign wr_done  = xfer_end && pwrite;
    assign rd_done  = xfer_end && !pwrite;
    assign err_done = xfer_end && pslverr;

    // One direction per completion, and an error always rides on one
    always_comb begin
        a_done_excl: assert (!(wr_done && rd_done) && (!err_done || wr_done || rd_done))
            else $error("completion pulses inconsistent");
    end

endmodule

/* source/apb_mon_regs.sv */
/*
 * APB3 monitor register block
 * Zero-wait configuration slave with CTRL, sticky W1C STATUS,
 * write, read and error counters, and the interrupt output
 */
`timescale 1ns/10ps
`include "apb_mon_params.svh"

module apb_mon_regs
    import apb_mon_pkg::*;
(
    input  logic      pclk,
    input  logic      presetn,
    input  logic      cfg_psel,
    input  logic      cfg_penable,
    input  logic      cfg_pwrite,
    input  cfg_addr_t cfg_paddr,
    input  data_t     cfg_pwdata,
    input  viol_t     viol,
    input  logic      wr_done,
    input  logic      rd_done,
    input  logic      err_done,
    output data_t     cfg_prdata,
    output logic      wait_limit_on,
    output wait_t     max_wait,
    output logic      irq
);

    localparam data_t CTRL_RST = `APB_MON_CTRL_RESET;

    logic       cfg_access;
    logic       cfg_wr;
    logic       cfg_rd;
    logic       sel_ctrl;
    logic       sel_status;
    logic [2:0] sel_cnt;
    logic [2:0] done_vec;
    logic       check_en;
    viol_t      w1c_mask;
    viol_t      status_q;
    viol_t      status_d;
    cnt_t       cnt_q [3];
    data_t      rd_word;

    // Every access is a single ACCESS cycle
    assign cfg_access = cfg_psel && cfg_penable;
    assign cfg_wr     = cfg_access && cfg_pwrite;
    assign cfg_rd     = cfg_access && !cfg_pwrite;

    // Address decode
    assign sel_ctrl   = (cfg_paddr == cfg_addr_t'(`APB_MON_REG_CTRL));
    assign sel_status = (cfg_paddr == cfg_addr_t'(`APB_MON_REG_STATUS));
    assign sel_cnt[0] = (cfg_paddr == cfg_addr_t'(`APB_MON_REG_WR_CNT));
    assign sel_cnt[1] = (cfg_paddr == cfg_addr_t'(`APB_MON_REG_RD_CNT));
    assign sel_cnt[2] = (cfg_paddr == cfg_addr_t'(`APB_MON_REG_ERR_CNT));

    // Counter slots in register order
    assign done_vec = {err_done, rd_done, wr_done};

    // CTRL fields
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            check_en      <= CTRL_RST[0];
            wait_limit_on <= CTRL_RST[1];
            max_wait      <= CTRL_RST[15:8];
        end else if (cfg_wr && sel_ctrl) begin
            check_en      <= cfg_pwdata[0];
            wait_limit_on <= cfg_pwdata[1];
            max_wait      <= cfg_pwdata[15:8];
        end
    end

    // W1C clear first, then new violations, so a same-edge hit survives
    assign w1c_mask = (cfg_wr && sel_status) ? viol_t'(cfg_pwdata) : '0;
    assign status_d = (status_q & ~w1c_mask) | (check_en ? viol : '0);

    // irq follows the next STATUS value so both change at one edge
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            status_q <= '0;
            irq      <= 1'b0;
        end else begin
            status_q <= status_d;
            irq      <= |status_d;
        end
    end

    // Wrapping counters, any write clears
    // a completion on the clearing edge still counts as one
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            for (int i = 0; i < 3; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (cfg_wr && sel_cnt[i]) begin
                    cnt_q[i] <= done_vec[i] ? cnt_t'(1) : '0;
                end else if (done_vec[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // Read mux, unmapped offsets read zero
    always_comb begin
        rd_word = '0;
        if (sel_ctrl) begin
            rd_word = data_t'({max_wait, 6'h00, wait_limit_on, check_en});
        end else if (sel_status) begin
            rd_word = data_t'(status_q);
        end else if (sel_cnt[0]) begin
            rd_word = data_t'(cnt_q[0]);
        end else if (sel_cnt[1]) begin
            rd_word = data_t'(cnt_q[1]);
        end else if (sel_cnt[2]) begin
            rd_word = data_t'(cnt_q[2]);
        end
    end

    // Valid only during the read ACCESS cycle
    assign cfg_prdata = cfg_rd ? rd_word : '0;

    // irq never set without a sticky bit behind it
    a_irq_has_cause: assert property (
        @(posedge pclk) disable iff (!presetn)
        irq |-> (status_q != '0)
    ) else $error("irq high with STATUS clear");

endmodule

/* source/apb_mon_top.sv */
/*
 * APB3 protocol monitor top
 * Phase tracker feeding the rule checker, with the register block
 * steering the checker and collecting its flags
 */
`timescale 1ns/10ps
`include "apb_mon_params.svh"

module apb_mon_top
    import apb_mon_pkg::*;
(
    input  logic      pclk,
    input  logic      presetn,
    // Monitored link, observed only
    input  logic      psel,
    input  logic      penable,
    input  addr_t     paddr,
    input  logic      pwrite,
    input  data_t     pwdata,
    input  logic      pready,
    input  data_t     prdata,     // observed for completeness, no rule on read data
    input  logic      pslverr,
    // Configuration slave
    input  logic      cfg_psel,
    input  logic      cfg_penable,
    input  logic      cfg_pwrite,
    input  cfg_addr_t cfg_paddr,
    input  data_t     cfg_pwdata,
    output data_t     cfg_prdata,
    output logic      irq
);

    // Tracker outputs
    apb_phase_e phase;
    apb_phase_e prev_phase;
    logic       prev_psel;
    addr_t      prev_paddr;
    logic       prev_pwrite;
    data_t      prev_pwdata;
    logic       first_cycle;
    wait_t      wait_cnt;

    // Checker and register links
    viol_t      viol;
    logic       wr_done;
    logic       rd_done;
    logic       err_done;
    logic       wait_limit_on;
    wait_t      max_wait;

    apb_phase_tracker u_tracker (
        .pclk        (pclk),
        .presetn     (presetn),
        .psel        (psel),
        .penable     (penable),
        .paddr       (paddr),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .pready      (pready),
        .phase       (phase),
        .prev_phase  (prev_phase),
        .prev_psel   (prev_psel),
        .prev_paddr  (prev_paddr),
        .prev_pwrite (prev_pwrite),
        .prev_pwdata (prev_pwdata),
        .first_cycle (first_cycle),
        .wait_cnt    (wait_cnt)
    );

    apb_rule_checker u_checker (
        .phase         (phase),
        .prev_phase    (prev_phase),
        .prev_psel     (prev_psel),
        .prev_paddr    (prev_paddr),
        .prev_pwrite   (prev_pwrite),
        .prev_pwdata   (prev_pwdata),
        .first_cycle   (first_cycle),
        .wait_cnt      (wait_cnt),
        .paddr         (paddr),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .penable       (penable),
        .pready        (pready),
        .pslverr       (pslverr),
        .wait_limit_on (wait_limit_on),
        .max_wait      (max_wait),
        .viol          (viol),
        .wr_done       (wr_done),
        .rd_done       (rd_done),
        .err_done      (err_done)
    );

    apb_mon_regs u_regs (
        .pclk          (pclk),
        .presetn       (presetn),
        .cfg_psel      (cfg_psel),
        .cfg_penable   (cfg_penable),
        .cfg_pwrite    (cfg_pwrite),
        .cfg_paddr     (cfg_paddr),
        .cfg_pwdata    (cfg_pwdata),
        .viol          (viol),
        .wr_done       (wr_done),
        .rd_done       (rd_done),
        .err_done      (err_done),
        .cfg_prdata    (cfg_prdata),
        .wait_limit_on (wait_limit_on),
        .max_wait      (max_wait),
        .irq           (irq)
    );

endmodule

/* tb/tb_apb_mon.sv */
/*
 * APB3 protocol monitor testbench
 * Plays master and slave on the monitored link, injects rule breaks one at a
 * time and checks STATUS, irq and the transfer counters against a model
 */
`timescale 1ns/10ps
`include "apb_mon_params.svh"

module tb_apb_mon
    import apb_mon_pkg::*;
();

    logic      pclk = 1'b0;
    logic      presetn;
    logic      psel;
    logic      penable;
    logic      pwrite;
    logic      pready;
    logic      pslverr;
    addr_t     paddr;
    data_t     pwdata;
    data_t     prdata;
    logic      cfg_psel;
    logic      cfg_penable;
    logic      cfg_pwrite;
    cfg_addr_t cfg_paddr;
    data_t     cfg_pwdata;
    data_t     cfg_prdata;
    logic      irq;

    // Model of the three counters
    cnt_t   wr_model;
    cnt_t   rd_model;
    cnt_t   err_model;
    int     errors = 0;
    int     checks = 0;
    integer seed = 71;

    apb_mon_top UUT (
        .pclk        (pclk),
        .presetn     (presetn),
        .psel        (psel),
        .penable     (penable),
        .paddr       (paddr),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .pready      (pready),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .cfg_psel    (cfg_psel),
        .cfg_penable (cfg_penable),
        .cfg_pwrite  (cfg_pwrite),
        .cfg_paddr   (cfg_paddr),
        .cfg_pwdata  (cfg_pwdata),
        .cfg_prdata  (cfg_prdata),
        .irq         (irq)
    );

    // 10 ns period
    always #5 pclk = ~pclk;

    // Expected STATUS after one injected sequence
    function automatic viol_t expected_status(input viol_t rules, input logic en,
                                              input logic limit_on, input wait_t max_w,
                                              input int wait_obs);
        viol_t st;
        st = rules;
        // Wait states beyond the limit
        if (limit_on && (wait_obs > int'(max_w))) begin
            st[V_WAIT_LIMIT] = 1'b1;
        end
        return en ? st : '0;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // Completed transfer seen by the model
    task automatic count_completion(input logic err);
        if (pwrite) begin
            wr_model++;
        end else begin
            rd_model++;
        end
        if (err) begin
            err_model++;
        end
    endtask

    // One monitored bus cycle, driven just after the rising edge
    task automatic bus_cycle(input logic sel, input logic en, input logic rdy,
                             input logic err);
        @(posedge pclk);
        #1;
        psel    = sel;
        penable = en;
        pready  = rdy;
        pslverr = err;
        prdata  = $random(seed);
        if (sel && en && rdy) begin
            count_completion(err);
        end
    endtask

    // Legal transfer, then one idle cycle with address and direction held
    task automatic transfer(input addr_t addr, input logic wr, input int nwait,
                            input logic err);
        bus_cycle(1'b1, 1'b0, 1'b0, 1'b0);
        paddr  = addr;
        pwrite = wr;
        pwdata = $random(seed);
        repeat (nwait) bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        bus_cycle(1'b1, 1'b1, 1'b1, err);
        bus_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // Breaks one rule, ends with an idle cycle past the flagging edge
    task automatic inject(input int rule);
        case (rule)
            V_SETUP_TO_ACCESS: begin
                bus_cycle(1'b1, 1'b0, 1'b0, 1'b0);
                bus_cycle(1'b0, 1'b0, 1'b0, 1'b0);
            end
            V_PENABLE_NO_PSEL: bus_cycle(1'b0, 1'b1, 1'b0, 1'b0);
            // ACCESS straight from idle
            V_PENABLE_FIRST:   bus_cycle(1'b1, 1'b1, 1'b1, 1'b0);
            V_SETUP_UNSTABLE: begin
                bus_cycle(1'b1, 1'b0, 1'b0, 1'b0);
                bus_cycle(1'b1, 1'b1, 1'b1, 1'b0);
                paddr = paddr ^ addr_t'(4);
            end
            V_WAIT_UNSTABLE: begin
                bus_cycle(1'b1, 1'b0, 1'b0, 1'b0);
                bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
                bus_cycle(1'b1, 1'b1, 1'b1, 1'b0);
                paddr = paddr ^ addr_t'(4);
            end
            // Caller sets the limit to one wait cycle
            V_WAIT_LIMIT:      transfer(paddr, pwrite, 2, 1'b0);
            V_PSLVERR_IDLE:    bus_cycle(1'b0, 1'b0, 1'b0, 1'b1);
            default: begin
                bus_cycle(1'b0, 1'b0, 1'b0, 1'b0);
                paddr = paddr + addr_t'('h10);
            end
        endcase
        bus_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input data_t data);
        @(posedge pclk);
        #1;
        cfg_psel   = 1'b1;
        cfg_pwrite = 1'b1;
        cfg_paddr  = addr;
        cfg_pwdata = data;
        @(posedge pclk);
        #1;
        cfg_penable = 1'b1;
        @(posedge pclk);
        #1;
        cfg_psel    = 1'b0;
        cfg_penable = 1'b0;
    endtask

    task automatic cfg_read(input cfg_addr_t addr, output data_t data);
        @(posedge pclk);
        #1;
        cfg_psel   = 1'b1;
        cfg_pwrite = 1'b0;
        cfg_paddr  = addr;
        @(posedge pclk);
        #1;
        cfg_penable = 1'b1;
        // Sample mid-cycle while read data is stable
        #3;
        data = cfg_prdata;
        @(posedge pclk);
        #1;
        cfg_psel    = 1'b0;
        cfg_penable = 1'b0;
    endtask

    task automatic read_check(input string name, input cfg_addr_t addr, input data_t exp);
        data_t got;
        cfg_read(addr, got);
        compare_value(name, got, exp);
    endtask

    task automatic check_counters();
        read_check("WR_CNT", `APB_MON_REG_WR_CNT, data_t'(wr_model));
        read_check("RD_CNT", `APB_MON_REG_RD_CNT, data_t'(rd_model));
        read_check("ERR_CNT", `APB_MON_REG_ERR_CNT, data_t'(err_model));
    endtask

    // Polls irq once per cycle up to a limit
    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while ((irq !== level) && (n < 20)) begin
            @(posedge pclk);
            #1;
            n++;
        end
        if (irq !== level) begin
            $display("Timeout while waiting for irq to become %0d", level);
            errors++;
        end
        compare_value("irq", irq, level);
    endtask

    initial begin
        integer r;
        viol_t  exp_st;
        presetn     = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        paddr       = '0;
        pwrite      = 1'b0;
        pwdata      = '0;
        pready      = 1'b0;
        prdata      = '0;
        pslverr     = 1'b0;
        cfg_psel    = 1'b0;
        cfg_penable = 1'b0;
        cfg_pwrite  = 1'b0;
        cfg_paddr   = '0;
        cfg_pwdata  = '0;
        wr_model    = '0;
        rd_model    = '0;
        err_model   = '0;
        repeat (10) @(posedge pclk);
        #1;
        presetn = 1'b1;

        // Reset values
        compare_value("irq", irq, 1'b0);
        read_check("CTRL", `APB_MON_REG_CTRL, `APB_MON_CTRL_RESET);
        read_check("STATUS", `APB_MON_REG_STATUS, '0);
        check_counters();

        // Random legal traffic
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            transfer(addr_t'($random(seed)), r[0], int'(r[3:2]), r[4]);
        end
        read_check("STATUS", `APB_MON_REG_STATUS, '0);
        wait_irq(1'b0);
        check_counters();
        cfg_write(`APB_MON_REG_WR_CNT, '0);
        cfg_write(`APB_MON_REG_RD_CNT, '0);
        cfg_write(`APB_MON_REG_ERR_CNT, '0);
        wr_model  = '0;
        rd_model  = '0;
        err_model = '0;
        check_counters();

        // Each rule alone, then W1C
        for (int k = 0; k < 8; k++) begin
            if (k == V_WAIT_LIMIT) begin
                cfg_write(`APB_MON_REG_CTRL, 32'h0000_0103);
                exp_st = expected_status('0, 1'b1, 1'b1, 8'd1, 2);
            end else begin
                exp_st = expected_status(viol_t'(1 << k), 1'b1, 1'b0, 8'd0,
                                         (k == V_WAIT_UNSTABLE) ? 1 : 0);
            end
            inject(k);
            wait_irq(1'b1);
            read_check("STATUS", `APB_MON_REG_STATUS, data_t'(exp_st));
            cfg_write(`APB_MON_REG_STATUS, data_t'(exp_st));
            read_check("STATUS", `APB_MON_REG_STATUS, '0);
            wait_irq(1'b0);
            cfg_write(`APB_MON_REG_CTRL, `APB_MON_CTRL_RESET);
        end

        // Wait limit of two cycles
        cfg_write(`APB_MON_REG_CTRL, 32'h0000_0203);
        transfer(paddr, 1'b1, 3, 1'b0);
        wait_irq(1'b1);
        exp_st = expected_status('0, 1'b1, 1'b1, 8'd2, 3);
        read_check("STATUS", `APB_MON_REG_STATUS, data_t'(exp_st));
        cfg_write(`APB_MON_REG_STATUS, 32'h0000_00ff);
        wait_irq(1'b0);
        transfer(paddr, 1'b0, 2, 1'b0);
        exp_st = expected_status('0, 1'b1, 1'b1, 8'd2, 2);
        read_check("STATUS", `APB_MON_REG_STATUS, data_t'(exp_st));
        wait_irq(1'b0);

        // Checking disabled, limit armed so every rule can fire
        cfg_write(`APB_MON_REG_CTRL, 32'h0000_0102);
        for (int k = 0; k < 8; k++) begin
            inject(k);
        end
        exp_st = expected_status(8'hff, 1'b0, 1'b1, 8'd1, 2);
        read_check("STATUS", `APB_MON_REG_STATUS, data_t'(exp_st));
        compare_value("irq", irq, 1'b0);
        check_counters();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+include
source/apb_mon_pkg.sv
source/apb_phase_tracker.sv
source/apb_rule_checker.sv
source/apb_mon_regs.sv
source/apb_mon_top.sv
tb/tb_apb_mon.sv

/* run_sim.sh */
#!/bin/sh
# Build the APB3 monitor testbench with Verilator and run it

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_apb_mon \
    -f src.f -o tb_apb_mon > build.log 2>&1 \
    && ./obj_dir/tb_apb_mon > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "TESTS PASSED" sim.log \
    && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }
